// File: logic/dsi_tx_pkg.sv
package dsi_tx_pkg;

    localparam logic [7:0] pkt_vss   = 8'h01;
    localparam logic [7:0] pkt_hss   = 8'h21;
    localparam logic [7:0] pkt_pps24 = 8'h3E;  // packed pixel, 24 bpp

    localparam logic [2:0] kind_none   = 3'd0;
    localparam logic [2:0] kind_lp_cmd = 3'd1;
    localparam logic [2:0] kind_vss    = 3'd2;
    localparam logic [2:0] kind_hss    = 3'd3;
    localparam logic [2:0] kind_line   = 3'd4;

    // lp flag, half flag, then the 32-bit word
    localparam int queue_width = 34;

    typedef struct packed {
        logic [7:0]  ecc;
        logic [15:0] word_count;
        logic [7:0]  data_id;
    } dsi_header_t;

    typedef union packed {
        dsi_header_t hdr;
        logic [31:0] data;  // payload or crc trailer
    } dsi_word_t;

    function automatic logic [7:0] dsi_ecc(input logic [23:0] hdr);
        logic [7:0] ecc;
        ecc    = 8'd0;
        ecc[0] = ^(hdr & 24'hF12CB7);
        ecc[1] = ^(hdr & 24'hF2555B);
        ecc[2] = ^(hdr & 24'h749A6D);
        ecc[3] = ^(hdr & 24'hB8E38E);
        ecc[4] = ^(hdr & 24'hDF03F0);
        ecc[5] = ^(hdr & 24'hEFFC00);
        return ecc;
    endfunction

endpackage

// File: logic/dsi_ctrl_regs.sv
module dsi_ctrl_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        send_cmd,
    input  logic [23:0] cmd_packet,
    input  logic [2:0]  lanes_number,
    input  logic        idle,
    output logic        cmd_pulse,
    output logic [23:0] cmd_header,
    output logic [2:0]  lanes
);
    logic send_cmd_q;
    logic send_cmd_rise;

    assign send_cmd_rise = send_cmd && !send_cmd_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            send_cmd_q <= 1'b0;
            cmd_pulse  <= 1'b0;
            lanes      <= 3'd1;
        end
        else
        begin
            send_cmd_q <= send_cmd;
            cmd_pulse  <= send_cmd_rise;  // rising edge
            if (idle)
                lanes <= lanes_number;  // only between frames
        end
    end

    always_ff @(posedge clk)
    begin
        if (send_cmd_rise)
            cmd_header <= cmd_packet;
    end

endmodule

// File: logic/dsi_video_timing.sv
module dsi_video_timing #(
    parameter int BLANK_TIME         = 100,
    parameter int BLANK_TIME_HBP_ACT = 100,
    parameter int VSA_LINES          = 100,
    parameter int VBP_LINES          = 100,
    parameter int ACT_LINES          = 100,
    parameter int VFP_LINES          = 100
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,
    input  logic       fifo_line_ready,
    input  logic       cmd_pulse,
    input  logic       pkt_done,
    output logic       pkt_req,
    output logic [2:0] pkt_kind,
    output logic       idle
);
    import dsi_tx_pkg::*;

    localparam logic [2:0] s_idle      = 3'd0;
    localparam logic [2:0] s_cmd       = 3'd1;
    localparam logic [2:0] s_vss       = 3'd2;
    localparam logic [2:0] s_vss_blank = 3'd3;
    localparam logic [2:0] s_hss       = 3'd4;
    localparam logic [2:0] s_hbp       = 3'd5;
    localparam logic [2:0] s_line      = 3'd6;
    localparam logic [2:0] s_blank     = 3'd7;

    localparam logic [1:0] ph_vsa = 2'd0;
    localparam logic [1:0] ph_vbp = 2'd1;
    localparam logic [1:0] ph_act = 2'd2;
    localparam logic [1:0] ph_vfp = 2'd3;

    logic [2:0]  state;
    logic [2:0]  state_next;
    logic [1:0]  phase;
    logic [1:0]  phase_next;
    logic [15:0] blank_cnt;
    logic [15:0] line_cnt;
    logic [15:0] phase_lines;
    logic        blank_done;
    logic        hbp_done;

    assign blank_done = (blank_cnt == 16'd0);
    assign hbp_done   = (blank_cnt == 16'(BLANK_TIME - BLANK_TIME_HBP_ACT));
    assign idle       = (state == s_idle);

    always_comb
    begin
        state_next = state;
        phase_next = phase;
        case (state)
            s_idle:
                if (enable && fifo_line_ready)
                    state_next = s_vss;
                else if (cmd_pulse)
                    state_next = s_cmd;
            s_cmd:
                if (pkt_done)
                    state_next = s_idle;
            s_vss:
                if (pkt_done)
                    state_next = s_vss_blank;
            s_vss_blank:
                if (blank_done)
                begin
                    state_next = s_hss;
                    phase_next = ph_vsa;
                end
            s_hss:
                if (pkt_done)
                    state_next = (phase == ph_act) ? s_hbp : s_blank;
            s_hbp:
                if (hbp_done)
                    state_next = s_line;
            s_line:
                if (pkt_done)
                    state_next = s_blank;  // hfp wait
            default:
                if (blank_done)
                begin
                    state_next = s_hss;
                    if (line_cnt == 16'd1)
                    begin
                        phase_next = phase + 2'd1;
                        if (phase == ph_vfp)
                            state_next = s_idle;
                    end
                end
        endcase
    end

    always_comb
    begin
        case (phase_next)
            ph_vsa:  phase_lines = 16'(VSA_LINES);
            ph_vbp:  phase_lines = 16'(VBP_LINES);
            ph_act:  phase_lines = 16'(ACT_LINES);
            default: phase_lines = 16'(VFP_LINES);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= s_idle;
            phase     <= ph_vsa;
            blank_cnt <= 16'd0;
            line_cnt  <= 16'd0;
        end
        else
        begin
            state <= state_next;
            phase <= phase_next;
            if (state_next != state)
                blank_cnt <= 16'(BLANK_TIME);
            else if (!blank_done)
                blank_cnt <= blank_cnt - 16'd1;
            if (state == s_vss_blank || phase_next != phase)
                line_cnt <= phase_lines;  // new phase
            else if (state == s_blank && blank_done)
                line_cnt <= line_cnt - 16'd1;
        end
    end

    always_comb
    begin
        pkt_req = 1'b1;
        case (state)
            s_cmd:   pkt_kind = kind_lp_cmd;
            s_vss:   pkt_kind = kind_vss;
            s_hss:   pkt_kind = kind_hss;
            s_line:  pkt_kind = kind_line;
            default:
            begin
                pkt_req  = 1'b0;
                pkt_kind = kind_none;
            end
        endcase
    end

endmodule

// File: logic/dsi_crc16.sv
module dsi_crc16 (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  logic        write,
    input  logic [31:0] data,
    output logic [15:0] crc
);
    // four bytes low first, each lsb first
    function automatic logic [15:0] crc_word(input logic [15:0] seed, input logic [31:0] d);
        logic [15:0] c;
        c = seed;
        for (int i = 0; i < 32; i++)
        begin
            if (c[0] ^ d[i])
                c = (c >> 1) ^ 16'h8408;  // reflected 0x1021
            else
                c = c >> 1;
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            crc <= 16'hFFFF;
        else if (clear)
            crc <= 16'hFFFF;
        else if (write)
            crc <= crc_word(crc, data);
    end

endmodule

// File: logic/dsi_packet_builder.sv
module dsi_packet_builder #(
    parameter int BYTES_IN_LINE = 1920
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               pkt_req,
    input  logic [2:0]                         pkt_kind,
    input  logic [23:0]                        cmd_header,
    input  logic [31:0]                        fifo_data,
    input  logic                               fifo_not_empty,
    input  logic                               fifo_line_ready,
    input  logic                               q_full,
    input  logic [15:0]                        crc,
    output logic                               pkt_done,
    output logic                               fifo_read_ack,
    output logic                               q_write,
    output logic [dsi_tx_pkg::queue_width-1:0] q_word,
    output logic                               crc_clear,
    output logic                               crc_write,
    output logic                               underflow
);
    import dsi_tx_pkg::*;

    localparam logic [1:0] st_header  = 2'd0;
    localparam logic [1:0] st_payload = 2'd1;
    localparam logic [1:0] st_trailer = 2'd2;

    logic [1:0]  stage;
    logic [15:0] words_left;
    logic [7:0]  hdr_id;
    logic [15:0] hdr_count;
    dsi_word_t   word;
    logic        lp;
    logic        half;
    logic        is_line;

    assign is_line   = (pkt_kind == kind_line);
    assign q_word    = {lp, half, word};
    assign crc_write = fifo_read_ack;

    always_comb
    begin
        hdr_count = 16'd0;
        case (pkt_kind)
            kind_lp_cmd:
            begin
                hdr_id    = cmd_header[7:0];
                hdr_count = cmd_header[23:8];
            end
            kind_vss:
                hdr_id = pkt_vss;
            kind_line:
            begin
                hdr_id    = pkt_pps24;
                hdr_count = 16'(BYTES_IN_LINE);
            end
            default:
                hdr_id = pkt_hss;
        endcase
    end

    always_comb
    begin
        word          = '0;
        lp            = 1'b0;
        half          = 1'b0;
        q_write       = 1'b0;
        fifo_read_ack = 1'b0;
        crc_clear     = 1'b0;
        pkt_done      = 1'b0;
        underflow     = 1'b0;
        case (stage)
            st_payload:
            begin
                word.data     = fifo_data;
                q_write       = !q_full && fifo_not_empty;
                fifo_read_ack = q_write;
            end
            st_trailer:
            begin
                word.data = {16'd0, crc};
                half      = 1'b1;  // crc is two bytes
                q_write   = !q_full;
                pkt_done  = q_write;
            end
            default:
            begin
                word.hdr.data_id    = hdr_id;
                word.hdr.word_count = hdr_count;
                word.hdr.ecc        = dsi_ecc({hdr_count, hdr_id});
                lp        = (pkt_kind == kind_lp_cmd);
                crc_clear = pkt_req && is_line;
                underflow = crc_clear && !fifo_line_ready;  // line not buffered yet
                q_write   = pkt_req && !q_full && (!is_line || fifo_line_ready);
                pkt_done  = q_write && !is_line;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            stage      <= st_header;
            words_left <= 16'd0;
        end
        else if (q_write)
        begin
            case (stage)
                st_payload:
                begin
                    words_left <= words_left - 16'd1;
                    if (words_left == 16'd1)
                        stage <= st_trailer;
                end
                st_trailer:
                    stage <= st_header;
                default:
                    if (is_line)
                    begin
                        stage      <= st_payload;
                        words_left <= 16'(BYTES_IN_LINE / 4);
                    end
            endcase
        end
    end

endmodule

// File: logic/dsi_lane_repacker.sv
module dsi_lane_repacker (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               q_write,
    input  logic [dsi_tx_pkg::queue_width-1:0] q_word,
    input  logic [2:0]                         lanes,
    input  logic [3:0]                         phy_full,
    output logic                               q_full,
    output logic [32:0]                        phy_data,
    output logic [3:0]                         phy_write
);
    import dsi_tx_pkg::*;

    logic [queue_width-1:0] mem [4];
    logic [queue_width-1:0] head;
    logic [1:0]             wr_ptr;
    logic [1:0]             rd_ptr;
    logic [2:0]             count;
    logic                   q_empty;
    logic                   push;
    logic [63:0]            sr;
    logic [63:0]            sr_shifted;
    logic [63:0]            in_bytes;
    logic [3:0]             sr_cnt;
    logic                   lp;
    logic [2:0]             eff_lanes;
    logic                   mode_block;
    logic                   full_out;
    logic                   out_write;
    logic [2:0]             out_n;
    logic [3:0]             remain;
    logic                   load;

    assign q_empty    = (count == 3'd0);
    assign q_full     = (count == 3'd4);
    assign push       = q_write && !q_full;
    assign head       = mem[rd_ptr];
    assign eff_lanes  = lp ? 3'd1 : lanes;
    // lp and hs bytes never share the shift register
    assign mode_block = !q_empty && (head[33] != lp);
    assign full_out   = (sr_cnt >= {1'b0, eff_lanes});
    assign out_write  = !(|phy_full) && (sr_cnt != 4'd0) && (full_out || q_empty || mode_block);
    assign out_n      = full_out ? eff_lanes : sr_cnt[2:0];
    assign remain     = out_write ? sr_cnt - {1'b0, out_n} : sr_cnt;
    assign load       = !q_empty && (remain <= 4'd4) && (!mode_block || remain == 4'd0);
    assign sr_shifted = out_write ? sr >> {out_n, 3'b000} : sr;
    assign in_bytes   = head[32] ? {48'd0, head[15:0]} : {32'd0, head[31:0]};
    assign phy_data   = {lp, sr[31:0]};
    assign phy_write  = out_write ? ~(4'hF << out_n) : 4'h0;  // lowest out_n lanes

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= q_word;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= 2'd0;
            rd_ptr <= 2'd0;
            count  <= 3'd0;
            sr     <= 64'd0;
            sr_cnt <= 4'd0;
            lp     <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 2'd1;
            if (load)
            begin
                rd_ptr <= rd_ptr + 2'd1;
                lp     <= head[33];
            end
            count  <= count + {2'b00, push} - {2'b00, load};
            sr     <= load ? sr_shifted | (in_bytes << {remain, 3'b000}) : sr_shifted;
            sr_cnt <= remain + (load ? (head[32] ? 4'd2 : 4'd4) : 4'd0);
        end
    end

endmodule

// File: logic/dsi_tx_packets_assembler.sv
module dsi_tx_packets_assembler #(
    parameter int LINE_WIDTH         = 640,
    parameter int BITS_PER_PIXEL     = 24,
    parameter int BLANK_TIME         = 100,
    parameter int BLANK_TIME_HBP_ACT = 100,
    parameter int VSA_LINES          = 100,
    parameter int VBP_LINES          = 100,
    parameter int ACT_LINES          = 100,
    parameter int VFP_LINES          = 100
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] fifo_data,
    input  logic        fifo_not_empty,
    input  logic        fifo_line_ready,
    output logic        fifo_read_ack,
    output logic [32:0] phy_data,
    output logic [3:0]  phy_write,
    input  logic [3:0]  phy_full,
    input  logic        enable,
    input  logic        send_cmd,
    input  logic [2:0]  lanes_number,
    input  logic [23:0] cmd_packet,
    output logic        pix_buffer_underflow_set
);
    import dsi_tx_pkg::*;

    localparam int BYTES_IN_LINE = LINE_WIDTH * BITS_PER_PIXEL / 8;  // multiple of 4

    logic                   cmd_pulse;
    logic [23:0]            cmd_header;
    logic [2:0]             lanes;
    logic                   idle;
    logic                   pkt_req;
    logic [2:0]             pkt_kind;
    logic                   pkt_done;
    logic                   q_write;
    logic [queue_width-1:0] q_word;
    logic                   q_full;
    logic                   crc_clear;
    logic                   crc_write;
    logic [15:0]            crc;

    dsi_ctrl_regs u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .send_cmd     (send_cmd),
        .cmd_packet   (cmd_packet),
        .lanes_number (lanes_number),
        .idle         (idle),
        .cmd_pulse    (cmd_pulse),
        .cmd_header   (cmd_header),
        .lanes        (lanes)
    );

    dsi_video_timing #(
        .BLANK_TIME         (BLANK_TIME),
        .BLANK_TIME_HBP_ACT (BLANK_TIME_HBP_ACT),
        .VSA_LINES          (VSA_LINES),
        .VBP_LINES          (VBP_LINES),
        .ACT_LINES          (ACT_LINES),
        .VFP_LINES          (VFP_LINES)
    ) u_timing (
        .clk             (clk),
        .rst_n           (rst_n),
        .enable          (enable),
        .fifo_line_ready (fifo_line_ready),
        .cmd_pulse       (cmd_pulse),
        .pkt_done        (pkt_done),
        .pkt_req         (pkt_req),
        .pkt_kind        (pkt_kind),
        .idle            (idle)
    );

    dsi_packet_builder #(
        .BYTES_IN_LINE (BYTES_IN_LINE)
    ) u_builder (
        .clk             (clk),
        .rst_n           (rst_n),
        .pkt_req         (pkt_req),
        .pkt_kind        (pkt_kind),
        .cmd_header      (cmd_header),
        .fifo_data       (fifo_data),
        .fifo_not_empty  (fifo_not_empty),
        .fifo_line_ready (fifo_line_ready),
        .q_full          (q_full),
        .crc             (crc),
        .pkt_done        (pkt_done),
        .fifo_read_ack   (fifo_read_ack),
        .q_write         (q_write),
        .q_word          (q_word),
        .crc_clear       (crc_clear),
        .crc_write       (crc_write),
        .underflow       (pix_buffer_underflow_set)
    );

    dsi_crc16 u_crc (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (crc_clear),
        .write (crc_write),
        .data  (fifo_data),
        .crc   (crc)
    );

    dsi_lane_repacker u_repacker (
        .clk       (clk),
        .rst_n     (rst_n),
        .q_write   (q_write),
        .q_word    (q_word),
        .lanes     (lanes),
        .phy_full  (phy_full),
        .q_full    (q_full),
        .phy_data  (phy_data),
        .phy_write (phy_write)
    );

endmodule

// File: sim/dsi_tx_props.sv
module dsi_tx_props (
    input logic        clk,
    input logic        rst_n,
    input logic [3:0]  phy_write,
    input logic [3:0]  phy_full,
    input logic [32:0] phy_data,
    input logic        fifo_read_ack,
    input logic        fifo_not_empty
);
    timeunit 1ns;
    timeprecision 100ps;

    lanes_from_zero: assert property (@(posedge clk) disable iff (!rst_n)
        phy_write inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
        else $error("phy_write lanes not contiguous from lane 0");

    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (|phy_full) |-> (phy_write == 4'h0))
        else $error("PHY write while phy_full is set");

    lp_single_lane: assert property (@(posedge clk) disable iff (!rst_n)
        (phy_write != 4'h0 && phy_data[32]) |-> (phy_write == 4'b0001))
        else $error("LP write on more than lane 0");

    pop_only_when_data: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_read_ack |-> fifo_not_empty)
        else $error("fifo_read_ack with the pixel fifo empty");

endmodule

bind dsi_tx_packets_assembler dsi_tx_props props_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .phy_write      (phy_write),
    .phy_full       (phy_full),
    .phy_data       (phy_data),
    .fifo_read_ack  (fifo_read_ack),
    .fifo_not_empty (fifo_not_empty)
);

// File: sim/tb_dsi_tx.sv
module tb_dsi_tx;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int line_width     = 8;
    localparam int bits_per_pixel = 24;
    localparam int blank_time     = 6;
    localparam int blank_hbp      = 3;
    localparam int vsa_lines      = 1;
    localparam int vbp_lines      = 1;
    localparam int act_lines      = 2;
    localparam int vfp_lines      = 1;
    localparam int bytes_in_line  = line_width * bits_per_pixel / 8;
    localparam int words_per_line = bytes_in_line / 4;
    localparam int frame_bytes    = 4 * (1 + vsa_lines + vbp_lines + act_lines + vfp_lines)
                                    + act_lines * (4 + bytes_in_line + 2);
    localparam int total_bytes    = 4 + 6 * frame_bytes;  // one command, six frames
    localparam int limit_cycles   = total_bytes * 40;

    localparam logic [7:0] id_vss   = 8'h01;
    localparam logic [7:0] id_hss   = 8'h21;
    localparam logic [7:0] id_pps24 = 8'h3E;

    // hamming syndrome of each header bit, bit 0 first
    localparam logic [5:0] ecc_syndrome [0:23] = '{
        6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
        6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
        6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
    };

    logic        clk;
    logic        rst_n;
    logic [31:0] fifo_data;
    logic        fifo_not_empty;
    logic        fifo_line_ready;
    logic        fifo_read_ack;
    logic [32:0] phy_data;
    logic [3:0]  phy_write;
    logic [3:0]  phy_full;
    logic        enable;
    logic        send_cmd;
    logic [2:0]  lanes_number;
    logic [23:0] cmd_packet;
    logic        pix_buffer_underflow_set;

    logic [31:0] pix_q [$];  // pixel fifo contents
    logic [8:0]  exp_q [$];  // expected {lp, byte}
    int          rd_idx;
    int          got_cnt;
    int          uflow_cnt;
    int          lane_limit;
    int          write_lanes;
    int          stream_errors;
    int          frame_errors;
    bit          bp_en;
    bit          popped;
    bit          byte_bad;
    bit          frame_bad;

    dsi_tx_packets_assembler #(
        .LINE_WIDTH         (line_width),
        .BITS_PER_PIXEL     (bits_per_pixel),
        .BLANK_TIME         (blank_time),
        .BLANK_TIME_HBP_ACT (blank_hbp),
        .VSA_LINES          (vsa_lines),
        .VBP_LINES          (vbp_lines),
        .ACT_LINES          (act_lines),
        .VFP_LINES          (vfp_lines)
    ) dsi_tx_packets_assembler_i (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .fifo_data                (fifo_data),
        .fifo_not_empty           (fifo_not_empty),
        .fifo_line_ready          (fifo_line_ready),
        .fifo_read_ack            (fifo_read_ack),
        .phy_data                 (phy_data),
        .phy_write                (phy_write),
        .phy_full                 (phy_full),
        .enable                   (enable),
        .send_cmd                 (send_cmd),
        .lanes_number             (lanes_number),
        .cmd_packet               (cmd_packet),
        .pix_buffer_underflow_set (pix_buffer_underflow_set)
    );

    always #5 clk = ~clk;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what,
                         output bit bad);
        bad = (got !== exp);
        if (bad)
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    function automatic logic [7:0] ecc_of(input logic [23:0] hdr);
        logic [5:0] syn;
        syn = 6'd0;
        for (int i = 0; i < 24; i++)
        begin
            if (hdr[i])
                syn = syn ^ ecc_syndrome[i];
        end
        return {2'b00, syn};
    endfunction

    function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        c = crc ^ {8'd0, b};
        for (int i = 0; i < 8; i++)
            c = c[0] ? (c >> 1) ^ 16'h8408 : c >> 1;
        return c;
    endfunction

    function automatic void push_byte(input logic [7:0] b, input logic lp);
        exp_q.push_back({lp, b});
    endfunction

    function automatic void push_header(input logic [7:0] id, input logic [15:0] wc,
                                        input logic lp);
        push_byte(id, lp);
        push_byte(wc[7:0], lp);
        push_byte(wc[15:8], lp);
        push_byte(ecc_of({wc, id}), lp);
    endfunction

    // reference byte stream of one frame, pixels from pix_q[first] on
    function automatic void expect_frame(input int first);
        logic [15:0] crc;
        logic [31:0] w;
        push_header(id_vss, 16'd0, 1'b0);
        for (int l = 0; l < vsa_lines + vbp_lines; l++)
            push_header(id_hss, 16'd0, 1'b0);
        for (int l = 0; l < act_lines; l++)
        begin
            push_header(id_hss, 16'd0, 1'b0);
            push_header(id_pps24, 16'(bytes_in_line), 1'b0);
            crc = 16'hFFFF;
            for (int k = 0; k < words_per_line; k++)
            begin
                w = pix_q[first + l * words_per_line + k];
                for (int b = 0; b < 4; b++)
                begin
                    push_byte(w[8*b +: 8], 1'b0);
                    crc = crc_byte(crc, w[8*b +: 8]);
                end
            end
            push_byte(crc[7:0], 1'b0);
            push_byte(crc[15:8], 1'b0);
        end
        for (int l = 0; l < vfp_lines; l++)
            push_header(id_hss, 16'd0, 1'b0);
    endfunction

    // pixel fifo model and phy back-pressure
    initial
    begin
        rd_idx         = 0;
        fifo_data      = 32'd0;
        fifo_not_empty = 1'b0;
        phy_full       = 4'h0;
        forever
        begin
            @(posedge clk);
            popped = fifo_read_ack;
            #1;
            if (popped)
                rd_idx++;
            phy_full       = (bp_en && $urandom % 3 == 0) ? 4'($urandom_range(1, 15)) : 4'h0;
            fifo_not_empty = (rd_idx < pix_q.size()) && !(bp_en && $urandom % 4 == 0);
            fifo_data      = (rd_idx < pix_q.size()) ? pix_q[rd_idx] : 32'd0;
        end
    end

    // byte collector, lane 0 first
    always @(posedge clk)
    begin
        if (rst_n && phy_write != 4'h0)
        begin
            write_lanes = 0;
            for (int i = 0; i < 4; i++)
            begin
                if (phy_write[i])
                begin
                    write_lanes++;
                    if (got_cnt < exp_q.size())
                    begin
                        check(32'({phy_data[32], phy_data[8*i +: 8]}), 32'(exp_q[got_cnt]),
                              $sformatf("byte %0d", got_cnt), byte_bad);
                        stream_errors += int'(byte_bad);
                    end
                    else
                    begin
                        $display("ERROR at %0t: PHY wrote byte %h when no byte was expected",
                                 $time, phy_data[8*i +: 8]);
                        stream_errors++;
                    end
                    got_cnt++;
                end
            end
            check(32'(write_lanes <= lane_limit), 32'd1, "write within lane count", byte_bad);
            stream_errors += int'(byte_bad);
        end
        if (pix_buffer_underflow_set)
            uflow_cnt++;
    end

    initial
    begin
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: byte stream not complete after %0d cycles", limit_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_stream_done();
        while (got_cnt < exp_q.size())
            wait_cycle();
        while (!dsi_tx_packets_assembler_i.idle)
            wait_cycle();
    endtask

    task automatic send_lp_cmd();
        cmd_packet = 24'($urandom);
        push_header(cmd_packet[7:0], cmd_packet[23:8], 1'b1);
        lane_limit = 1;
        send_cmd   = 1'b1;
        wait_cycle();
        wait_cycle();
        send_cmd = 1'b0;
        wait_stream_done();
    endtask

    task automatic run_frame(input logic [2:0] lane_count, input bit bp, input bit starve);
        int first;
        int pops_before;
        int uflow_before;
        first = pix_q.size();
        for (int i = 0; i < act_lines * words_per_line; i++)
            pix_q.push_back($urandom);
        expect_frame(first);
        lane_limit   = int'(lane_count);
        lanes_number = lane_count;
        bp_en        = bp;
        pops_before  = rd_idx;
        uflow_before = uflow_cnt;
        while (!dsi_tx_packets_assembler_i.idle)
            wait_cycle();
        enable = 1'b1;
        while (dsi_tx_packets_assembler_i.idle)
            wait_cycle();
        enable = 1'b0;
        if (starve)
        begin
            fifo_line_ready = 1'b0;  // first line not buffered
            while (uflow_cnt == uflow_before)
                wait_cycle();
            repeat (4) wait_cycle();
            fifo_line_ready = 1'b1;
        end
        wait_stream_done();
        bp_en = 1'b0;
        check(32'(rd_idx - pops_before), 32'(act_lines * words_per_line), "fifo pops",
              frame_bad);
        frame_errors += int'(frame_bad);
        check(32'(uflow_cnt != uflow_before), 32'(starve), "underflow seen", frame_bad);
        frame_errors += int'(frame_bad);
    endtask

    initial
    begin
        void'($urandom(32'h827e));
        clk             = 1'b0;
        rst_n           = 1'b0;
        enable          = 1'b0;
        send_cmd        = 1'b0;
        lanes_number    = 3'd4;
        cmd_packet      = 24'd0;
        fifo_line_ready = 1'b1;
        lane_limit      = 4;
        bp_en           = 1'b0;
        got_cnt         = 0;
        uflow_cnt       = 0;
        stream_errors   = 0;
        frame_errors    = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_cycle();
        send_lp_cmd();
        run_frame(3'd4, 1'b0, 1'b0);
        run_frame(3'd1, 1'b0, 1'b0);
        run_frame(3'd2, 1'b0, 1'b0);
        run_frame(3'd3, 1'b0, 1'b0);
        run_frame(3'($urandom_range(1, 4)), 1'b1, 1'b0);
        run_frame(3'd4, 1'b0, 1'b1);
        repeat (10) wait_cycle();
        check(32'(got_cnt), 32'(exp_q.size()), "bytes on the PHY", frame_bad);
        frame_errors += int'(frame_bad);
        $display("bytes checked %0d, stream errors %0d, frame errors %0d",
                 got_cnt, stream_errors, frame_errors);
        if (stream_errors + frame_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: dsi_tx_packets_assembler.f
logic/dsi_tx_pkg.sv
logic/dsi_ctrl_regs.sv
logic/dsi_video_timing.sv
logic/dsi_crc16.sv
logic/dsi_packet_builder.sv
logic/dsi_lane_repacker.sv
logic/dsi_tx_packets_assembler.sv
sim/dsi_tx_props.sv
sim/tb_dsi_tx.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_dsi_tx -f dsi_tx_packets_assembler.f -o tb_dsi_tx
./obj_dir/tb_dsi_tx | tee sim.log
if grep -q "TESTS FAILED" sim.log
then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
